//--- design/ddr3_sched_pkg.sv
`default_nettype none

package ddr3_sched_pkg;

  // transaction id carried from request to data layer
  localparam int TID_BITS = 4;

  // 1Gb x16 device: 13 row bits, 3 bank bits, 10 column bits
  localparam int ROW_BITS = 13;
  localparam int BANK_BITS = 3;
  // requests are burst aligned, so the low column bits never travel
  localparam int BURST_BITS = 3;
  localparam int COL_BITS = 7;

  // request address is {row, bank, col}
  localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;
  localparam int COL_LSB = 0;
  localparam int BANK_LSB = COL_LSB + COL_BITS;
  localparam int ROW_LSB = BANK_LSB + BANK_BITS;

  // auto-precharge flag in the column command address
  localparam int A10_BIT = 10;

  // {ras_n, cas_n, we_n} command encodings
  typedef enum logic [2:0] {
    CMD_MODE = 3'b000,
    CMD_REFR = 3'b001,
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOOP = 3'b111
  } ddr3_cmd_e;

  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    ST_ACTV = 3'd1,
    ST_READ = 3'd2,
    ST_WRIT = 3'd3,
    ST_PREC = 3'd4,
    ST_REFR = 3'd5
  } sched_state_e;

endpackage

`default_nettype wire

//--- design/ddr3_req_decode.sv
`default_nettype none

module ddr3_req_decode (
  input  wire                                  mem_rdreq_i,
  input  wire                                  mem_rdlst_i,
  input  wire  [ddr3_sched_pkg::TID_BITS-1:0]  mem_rdtid_i,
  input  wire  [ddr3_sched_pkg::ADDR_BITS-1:0] mem_rdadr_i,
  input  wire                                  mem_wrreq_i,
  input  wire                                  mem_wrlst_i,
  input  wire  [ddr3_sched_pkg::TID_BITS-1:0]  mem_wrtid_i,
  input  wire  [ddr3_sched_pkg::ADDR_BITS-1:0] mem_wradr_i,
  input  wire                                  in_burst_i,
  input  wire                                  burst_write_i,
  input  wire  [ddr3_sched_pkg::ROW_BITS-1:0]  open_row_i,
  input  wire  [ddr3_sched_pkg::BANK_BITS-1:0] open_bank_i,
  output logic                                 sel_valid_o,
  output logic                                 sel_write_o,
  output logic                                 sel_last_o,
  output logic [ddr3_sched_pkg::TID_BITS-1:0]  sel_tid_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  sel_row_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] sel_bank_o,
  output logic [ddr3_sched_pkg::COL_BITS-1:0]  sel_col_o,
  output logic                                 same_row_o
);
  import ddr3_sched_pkg::*;

  logic                 use_wr;
  logic [ADDR_BITS-1:0] sel_adr;

  // an open burst keeps its own port and otherwise read wins
  assign use_wr = in_burst_i ? burst_write_i : !mem_rdreq_i;

  assign sel_write_o = use_wr;
  assign sel_valid_o = use_wr ? mem_wrreq_i : mem_rdreq_i;
  assign sel_last_o  = use_wr ? mem_wrlst_i : mem_rdlst_i;
  assign sel_tid_o   = use_wr ? mem_wrtid_i : mem_rdtid_i;
  assign sel_adr     = use_wr ? mem_wradr_i : mem_rdadr_i;

  // fixed mapping with row above bank above column
  assign sel_row_o  = sel_adr[ROW_LSB +: ROW_BITS];
  assign sel_bank_o = sel_adr[BANK_LSB +: BANK_BITS];
  assign sel_col_o  = sel_adr[COL_LSB +: COL_BITS];

  // row hit against the row the fsm holds open
  // only meaningful while a burst is open
  assign same_row_o = (sel_row_o == open_row_i) && (sel_bank_o == open_bank_i);

endmodule

`default_nettype wire

//--- design/ddr3_cmd_fsm.sv
`default_nettype none

module ddr3_cmd_fsm (
  input  wire                                  clock_i,
  input  wire                                  reset_i,
  input  wire                                  sel_valid_i,
  input  wire                                  sel_write_i,
  input  wire                                  sel_last_i,
  input  wire  [ddr3_sched_pkg::TID_BITS-1:0]  sel_tid_i,
  input  wire  [ddr3_sched_pkg::ROW_BITS-1:0]  sel_row_i,
  input  wire  [ddr3_sched_pkg::BANK_BITS-1:0] sel_bank_i,
  input  wire  [ddr3_sched_pkg::COL_BITS-1:0]  sel_col_i,
  input  wire                                  same_row_i,
  input  wire                                  ddl_rdy_i,
  input  wire                                  ddl_ref_i,
  input  wire                                  cfg_req_i,
  input  wire  ddr3_sched_pkg::ddr3_cmd_e      cfg_cmd_i,
  input  wire  [ddr3_sched_pkg::BANK_BITS-1:0] cfg_ba_i,
  input  wire  [ddr3_sched_pkg::ROW_BITS-1:0]  cfg_adr_i,
  output logic                                 in_burst_o,
  output logic                                 burst_write_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  open_row_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] open_bank_o,
  output logic                                 nxt_req_o,
  output ddr3_sched_pkg::ddr3_cmd_e            nxt_cmd_o,
  output logic [ddr3_sched_pkg::TID_BITS-1:0]  nxt_tid_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] nxt_ba_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  nxt_adr_o,
  output logic                                 accept_pulse_o,
  output logic                                 accept_write_o,
  output logic                                 reject_pulse_o,
  output logic                                 reject_write_o
);
  import ddr3_sched_pkg::*;

  sched_state_e         state_q;
  sched_state_e         state_d;
  logic                 burst_q;
  logic                 burst_d;
  logic                 write_q;
  logic                 last_q;
  logic                 hold_q;
  logic [ROW_BITS-1:0]  row_q;
  logic [BANK_BITS-1:0] bank_q;
  logic                 ld_open;
  logic                 ld_col;
  logic                 req_ok;
  ddr3_cmd_e            col_cmd;
  logic [ROW_BITS-1:0]  col_adr;

  // the requester still holds its old request in the ack/err cycle
  assign req_ok = sel_valid_i && !hold_q;

  // column command of the open burst
  assign col_cmd = write_q ? CMD_WRIT : CMD_READ;

  // column address is {pad, a10, col, burst offset}
  always_comb begin
    col_adr = '0;
    col_adr[BURST_BITS +: COL_BITS] = sel_col_i;
    col_adr[A10_BIT] = sel_last_i;
  end

  always_comb begin
    state_d        = state_q;
    burst_d        = burst_q;
    ld_open        = 1'b0;
    ld_col         = 1'b0;
    nxt_req_o      = 1'b0;
    nxt_cmd_o      = CMD_NOOP;
    nxt_tid_o      = sel_tid_i;
    nxt_ba_o       = bank_q;
    nxt_adr_o      = col_adr;
    accept_pulse_o = 1'b0;
    reject_pulse_o = 1'b0;
    if (reset_i) begin
      // configuration and init commands go straight to the data layer
      nxt_req_o = cfg_req_i;
      nxt_cmd_o = cfg_cmd_i;
      nxt_ba_o  = cfg_ba_i;
      nxt_adr_o = cfg_adr_i;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!burst_q && ddl_ref_i) begin
            // refresh only with every bank closed
            nxt_req_o = 1'b1;
            nxt_cmd_o = CMD_REFR;
            state_d   = ST_REFR;
          end else if (req_ok && !burst_q) begin
            // first request of a burst opens its row
            nxt_req_o = 1'b1;
            nxt_cmd_o = CMD_ACTV;
            nxt_ba_o  = sel_bank_i;
            nxt_adr_o = sel_row_i;
            ld_open   = 1'b1;
            burst_d   = 1'b1;
            state_d   = ST_ACTV;
          end else if (req_ok && same_row_i) begin
            // follow-on hit goes straight into the open row
            nxt_req_o = 1'b1;
            nxt_cmd_o = col_cmd;
            ld_col    = 1'b1;
            state_d   = write_q ? ST_WRIT : ST_READ;
          end else if (req_ok) begin
            // follow-on miss, close the open bank (a10 low)
            nxt_req_o = 1'b1;
            nxt_cmd_o = CMD_PREC;
            nxt_adr_o = '0;
            state_d   = ST_PREC;
          end
        end
        ST_ACTV: begin
          // activate is leaving, the column command follows it
          nxt_req_o = 1'b1;
          nxt_cmd_o = col_cmd;
          ld_col    = 1'b1;
          state_d   = write_q ? ST_WRIT : ST_READ;
        end
        ST_READ, ST_WRIT: begin
          accept_pulse_o = ddl_rdy_i;
          state_d        = ST_IDLE;
          // auto-precharge has closed the row
          if (last_q) begin
            burst_d = 1'b0;
          end
        end
        ST_PREC: begin
          reject_pulse_o = ddl_rdy_i;
          burst_d        = 1'b0;
          state_d        = ST_IDLE;
        end
        ST_REFR: begin
          // data layer holds ddl_ref_i until refresh is done
          if (!ddl_ref_i) begin
            state_d = ST_IDLE;
          end
        end
        default: state_d = ST_IDLE;
      endcase
    end
  end

  // all progress waits on ddl_rdy_i, which stalls the whole scheduler
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      burst_q <= 1'b0;
      write_q <= 1'b0;
      hold_q  <= 1'b0;
    end else begin
      hold_q <= accept_pulse_o || reject_pulse_o;
      if (ddl_rdy_i) begin
        state_q <= state_d;
        burst_q <= burst_d;
        if (ld_open) begin
          write_q <= sel_write_i;
        end
      end
    end
  end

  // row, bank and last flag of the burst in flight
  always_ff @(posedge clock_i) begin
    if (ddl_rdy_i && ld_open) begin
      row_q  <= sel_row_i;
      bank_q <= sel_bank_i;
    end
    if (ddl_rdy_i && ld_col) begin
      last_q <= sel_last_i;
    end
  end

  assign in_burst_o     = burst_q;
  assign burst_write_o  = write_q;
  assign open_row_o     = row_q;
  assign open_bank_o    = bank_q;
  assign accept_write_o = (state_q == ST_WRIT);
  assign reject_write_o = write_q;

  a_state_legal : assert property (@(posedge clock_i) disable iff (reset_i)
    state_q inside {ST_IDLE, ST_ACTV, ST_READ, ST_WRIT, ST_PREC, ST_REFR});

  // a decided command must not move while the data layer stalls,
  // which also relies on the requester holding its inputs
  a_stall_stable : assert property (@(posedge clock_i) disable iff (reset_i)
    nxt_req_o && (state_q != ST_IDLE) && !ddl_rdy_i
    |=> $stable({nxt_req_o, nxt_cmd_o, nxt_tid_o, nxt_ba_o, nxt_adr_o}));

endmodule

`default_nettype wire

//--- design/ddr3_resp_gen.sv
`default_nettype none

module ddr3_resp_gen (
  input  wire                                  clock_i,
  input  wire                                  reset_i,
  input  wire                                  ddl_rdy_i,
  input  wire                                  nxt_req_i,
  input  wire  ddr3_sched_pkg::ddr3_cmd_e      nxt_cmd_i,
  input  wire  [ddr3_sched_pkg::TID_BITS-1:0]  nxt_tid_i,
  input  wire  [ddr3_sched_pkg::BANK_BITS-1:0] nxt_ba_i,
  input  wire  [ddr3_sched_pkg::ROW_BITS-1:0]  nxt_adr_i,
  input  wire                                  accept_pulse_i,
  input  wire                                  accept_write_i,
  input  wire                                  reject_pulse_i,
  input  wire                                  reject_write_i,
  output logic                                 ddl_req_o,
  output ddr3_sched_pkg::ddr3_cmd_e            ddl_cmd_o,
  output logic [ddr3_sched_pkg::TID_BITS-1:0]  ddl_tid_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  ddl_adr_o,
  output logic                                 mem_wrack_o,
  output logic                                 mem_rdack_o,
  output logic                                 mem_wrerr_o,
  output logic                                 mem_rderr_o,
  output logic                                 cfg_rdy_o
);
  import ddr3_sched_pkg::*;

  logic load;

  // with ddl_rdy_i high the slot is either accepted or empty
  // during reset the slot follows the configuration port every cycle
  assign load = reset_i || ddl_rdy_i;

  always_ff @(posedge clock_i) begin
    if (load) begin
      ddl_req_o <= nxt_req_i;
      ddl_cmd_o <= nxt_cmd_i;
      ddl_tid_o <= nxt_tid_i;
      ddl_ba_o  <= nxt_ba_i;
      ddl_adr_o <= nxt_adr_i;
    end
  end

  // one-cycle strobes, steered to the port that owns the command
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      mem_wrack_o <= 1'b0;
      mem_rdack_o <= 1'b0;
      mem_wrerr_o <= 1'b0;
      mem_rderr_o <= 1'b0;
    end else begin
      mem_wrack_o <= accept_pulse_i && accept_write_i;
      mem_rdack_o <= accept_pulse_i && !accept_write_i;
      mem_wrerr_o <= reject_pulse_i && reject_write_i;
      mem_rderr_o <= reject_pulse_i && !reject_write_i;
    end
  end

  // config port sees the data layer's ready directly
  assign cfg_rdy_o = ddl_rdy_i;

  a_ack_err_excl : assert property (@(posedge clock_i) disable iff (reset_i)
    !(mem_wrack_o && mem_wrerr_o) && !(mem_rdack_o && mem_rderr_o));

  // a write ack only ever follows an accepted WRITE
  a_wrack_src : assert property (@(posedge clock_i) disable iff (reset_i)
    mem_wrack_o |-> $past(ddl_req_o && ddl_rdy_i && ddl_cmd_o == CMD_WRIT));

endmodule

`default_nettype wire

//--- design/ddr3_sched_top.sv
`default_nettype none

module ddr3_sched_top (
  input  wire                                  clock_i,
  input  wire                                  reset_i,
  input  wire                                  mem_wrreq_i,
  input  wire                                  mem_wrlst_i,
  input  wire  [ddr3_sched_pkg::TID_BITS-1:0]  mem_wrtid_i,
  input  wire  [ddr3_sched_pkg::ADDR_BITS-1:0] mem_wradr_i,
  output logic                                 mem_wrack_o,
  output logic                                 mem_wrerr_o,
  input  wire                                  mem_rdreq_i,
  input  wire                                  mem_rdlst_i,
  input  wire  [ddr3_sched_pkg::TID_BITS-1:0]  mem_rdtid_i,
  input  wire  [ddr3_sched_pkg::ADDR_BITS-1:0] mem_rdadr_i,
  output logic                                 mem_rdack_o,
  output logic                                 mem_rderr_o,
  input  wire                                  cfg_req_i,
  input  wire  ddr3_sched_pkg::ddr3_cmd_e      cfg_cmd_i,
  input  wire  [ddr3_sched_pkg::BANK_BITS-1:0] cfg_ba_i,
  input  wire  [ddr3_sched_pkg::ROW_BITS-1:0]  cfg_adr_i,
  output logic                                 cfg_rdy_o,
  output logic                                 ddl_req_o,
  output ddr3_sched_pkg::ddr3_cmd_e            ddl_cmd_o,
  output logic [ddr3_sched_pkg::TID_BITS-1:0]  ddl_tid_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  ddl_adr_o,
  input  wire                                  ddl_rdy_i,
  input  wire                                  ddl_ref_i
);
  import ddr3_sched_pkg::*;

  // decode to execute
  logic                 sel_valid;
  logic                 sel_write;
  logic                 sel_last;
  logic [TID_BITS-1:0]  sel_tid;
  logic [ROW_BITS-1:0]  sel_row;
  logic [BANK_BITS-1:0] sel_bank;
  logic [COL_BITS-1:0]  sel_col;
  logic                 same_row;

  // execute back to decode
  logic                 in_burst;
  logic                 burst_write;
  logic [ROW_BITS-1:0]  open_row;
  logic [BANK_BITS-1:0] open_bank;

  // execute to result
  logic                 nxt_req;
  ddr3_cmd_e            nxt_cmd;
  logic [TID_BITS-1:0]  nxt_tid;
  logic [BANK_BITS-1:0] nxt_ba;
  logic [ROW_BITS-1:0]  nxt_adr;
  logic                 accept_pulse;
  logic                 accept_write;
  logic                 reject_pulse;
  logic                 reject_write;

  ddr3_req_decode ddr3_req_decode_inst (
    .mem_rdreq_i   (mem_rdreq_i),
    .mem_rdlst_i   (mem_rdlst_i),
    .mem_rdtid_i   (mem_rdtid_i),
    .mem_rdadr_i   (mem_rdadr_i),
    .mem_wrreq_i   (mem_wrreq_i),
    .mem_wrlst_i   (mem_wrlst_i),
    .mem_wrtid_i   (mem_wrtid_i),
    .mem_wradr_i   (mem_wradr_i),
    .in_burst_i    (in_burst),
    .burst_write_i (burst_write),
    .open_row_i    (open_row),
    .open_bank_i   (open_bank),
    .sel_valid_o   (sel_valid),
    .sel_write_o   (sel_write),
    .sel_last_o    (sel_last),
    .sel_tid_o     (sel_tid),
    .sel_row_o     (sel_row),
    .sel_bank_o    (sel_bank),
    .sel_col_o     (sel_col),
    .same_row_o    (same_row)
  );

  ddr3_cmd_fsm ddr3_cmd_fsm_inst (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .sel_valid_i    (sel_valid),
    .sel_write_i    (sel_write),
    .sel_last_i     (sel_last),
    .sel_tid_i      (sel_tid),
    .sel_row_i      (sel_row),
    .sel_bank_i     (sel_bank),
    .sel_col_i      (sel_col),
    .same_row_i     (same_row),
    .ddl_rdy_i      (ddl_rdy_i),
    .ddl_ref_i      (ddl_ref_i),
    .cfg_req_i      (cfg_req_i),
    .cfg_cmd_i      (cfg_cmd_i),
    .cfg_ba_i       (cfg_ba_i),
    .cfg_adr_i      (cfg_adr_i),
    .in_burst_o     (in_burst),
    .burst_write_o  (burst_write),
    .open_row_o     (open_row),
    .open_bank_o    (open_bank),
    .nxt_req_o      (nxt_req),
    .nxt_cmd_o      (nxt_cmd),
    .nxt_tid_o      (nxt_tid),
    .nxt_ba_o       (nxt_ba),
    .nxt_adr_o      (nxt_adr),
    .accept_pulse_o (accept_pulse),
    .accept_write_o (accept_write),
    .reject_pulse_o (reject_pulse),
    .reject_write_o (reject_write)
  );

  ddr3_resp_gen ddr3_resp_gen_inst (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .ddl_rdy_i      (ddl_rdy_i),
    .nxt_req_i      (nxt_req),
    .nxt_cmd_i      (nxt_cmd),
    .nxt_tid_i      (nxt_tid),
    .nxt_ba_i       (nxt_ba),
    .nxt_adr_i      (nxt_adr),
    .accept_pulse_i (accept_pulse),
    .accept_write_i (accept_write),
    .reject_pulse_i (reject_pulse),
    .reject_write_i (reject_write),
    .ddl_req_o      (ddl_req_o),
    .ddl_cmd_o      (ddl_cmd_o),
    .ddl_tid_o      (ddl_tid_o),
    .ddl_ba_o       (ddl_ba_o),
    .ddl_adr_o      (ddl_adr_o),
    .mem_wrack_o    (mem_wrack_o),
    .mem_rdack_o    (mem_rdack_o),
    .mem_wrerr_o    (mem_wrerr_o),
    .mem_rderr_o    (mem_rderr_o),
    .cfg_rdy_o      (cfg_rdy_o)
  );

endmodule

`default_nettype wire

//--- tests/ddr3_sched_tb.sv
`default_nettype none

module ddr3_sched_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ddr3_sched_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 16;
  // ready is forced high after this many low cycles
  localparam int MAX_STALL = 6;
  // upper bound on requests issued by all scenarios
  localparam int N_REQ = 40;
  // each request costs a few stalled commands plus refresh slots
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_REQ * 8 * (MAX_STALL + 1);

  typedef struct packed {
    logic [2:0]           cmd;
    logic [TID_BITS-1:0]  tid;
    logic [BANK_BITS-1:0] ba;
    logic [ROW_BITS-1:0]  adr;
  } cmd_t;

  typedef struct packed {
    logic                 wr;
    logic                 lst;
    logic [TID_BITS-1:0]  tid;
    logic [ADDR_BITS-1:0] adr;
    logic                 ack;
  } req_t;

  logic                 clock_i;
  logic                 reset_i;
  logic                 mem_wrreq_i;
  logic                 mem_wrlst_i;
  logic [TID_BITS-1:0]  mem_wrtid_i;
  logic [ADDR_BITS-1:0] mem_wradr_i;
  logic                 mem_wrack_o;
  logic                 mem_wrerr_o;
  logic                 mem_rdreq_i;
  logic                 mem_rdlst_i;
  logic [TID_BITS-1:0]  mem_rdtid_i;
  logic [ADDR_BITS-1:0] mem_rdadr_i;
  logic                 mem_rdack_o;
  logic                 mem_rderr_o;
  logic                 cfg_req_i;
  ddr3_cmd_e            cfg_cmd_i;
  logic [BANK_BITS-1:0] cfg_ba_i;
  logic [ROW_BITS-1:0]  cfg_adr_i;
  logic                 cfg_rdy_o;
  logic                 ddl_req_o;
  ddr3_cmd_e            ddl_cmd_o;
  logic [TID_BITS-1:0]  ddl_tid_o;
  logic [BANK_BITS-1:0] ddl_ba_o;
  logic [ROW_BITS-1:0]  ddl_adr_o;
  logic                 ddl_rdy_i;
  logic                 ddl_ref_i;

  integer seed = 32'h5392;

  // expected and accepted command streams
  cmd_t exp_q[$];
  cmd_t acc_q[$];
  req_t rd_list[$];
  req_t wr_list[$];

  // reference model of the open burst
  logic                 m_open;
  logic [ROW_BITS-1:0]  m_row;
  logic [BANK_BITS-1:0] m_bank;
  logic [TID_BITS-1:0]  next_tid;

  // data-layer model state
  int                   stall_cnt;
  logic                 held;
  cmd_t                 held_cmd;
  logic                 ref_pending;
  logic                 ref_when_loaded;
  int                   refresh_count;

  ddr3_sched_top ddr3_sched_top_inst (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .mem_wrreq_i (mem_wrreq_i),
    .mem_wrlst_i (mem_wrlst_i),
    .mem_wrtid_i (mem_wrtid_i),
    .mem_wradr_i (mem_wradr_i),
    .mem_wrack_o (mem_wrack_o),
    .mem_wrerr_o (mem_wrerr_o),
    .mem_rdreq_i (mem_rdreq_i),
    .mem_rdlst_i (mem_rdlst_i),
    .mem_rdtid_i (mem_rdtid_i),
    .mem_rdadr_i (mem_rdadr_i),
    .mem_rdack_o (mem_rdack_o),
    .mem_rderr_o (mem_rderr_o),
    .cfg_req_i   (cfg_req_i),
    .cfg_cmd_i   (cfg_cmd_i),
    .cfg_ba_i    (cfg_ba_i),
    .cfg_adr_i   (cfg_adr_i),
    .cfg_rdy_o   (cfg_rdy_o),
    .ddl_req_o   (ddl_req_o),
    .ddl_cmd_o   (ddl_cmd_o),
    .ddl_tid_o   (ddl_tid_o),
    .ddl_ba_o    (ddl_ba_o),
    .ddl_adr_o   (ddl_adr_o),
    .ddl_rdy_i   (ddl_rdy_i),
    .ddl_ref_i   (ddl_ref_i)
  );

  always #(CLK_PERIOD / 2) clock_i = ~clock_i;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_error("value check failed");
    end
  endtask

  function automatic logic [31:0] rand_bits();
    return $random(seed);
  endfunction

  function automatic logic [ADDR_BITS-1:0] make_addr(input logic [ROW_BITS-1:0] row,
                                                     input logic [BANK_BITS-1:0] bank,
                                                     input logic [COL_BITS-1:0] col);
    return {row, bank, col};
  endfunction

  // commands the data layer should see for one request given the open burst
  function automatic int expected_cmds(input req_t r, input logic open,
                                       input logic [ROW_BITS-1:0] orow,
                                       input logic [BANK_BITS-1:0] obank,
                                       output cmd_t c0, output cmd_t c1);
    logic [ROW_BITS-1:0]  row;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  cadr;
    logic [2:0]           ccmd;
    row  = r.adr[ADDR_BITS-1 -: ROW_BITS];
    bank = r.adr[COL_BITS +: BANK_BITS];
    // request column counts bursts of eight
    cadr = {{(ROW_BITS - COL_BITS){1'b0}}, r.adr[COL_BITS-1:0]} << 3;
    cadr[A10_BIT] = r.lst;
    ccmd = r.wr ? CMD_WRIT : CMD_READ;
    c0 = '0;
    c1 = '0;
    if (open && (row != orow || bank != obank)) begin
      // miss closes the open bank with a10 low
      c0 = '{cmd: CMD_PREC, tid: r.tid, ba: obank, adr: '0};
      return 1;
    end
    if (open) begin
      c0 = '{cmd: ccmd, tid: r.tid, ba: obank, adr: cadr};
      return 1;
    end
    c0 = '{cmd: CMD_ACTV, tid: r.tid, ba: bank, adr: row};
    c1 = '{cmd: ccmd, tid: r.tid, ba: bank, adr: cadr};
    return 2;
  endfunction

  task automatic plan_request(input logic wr, input logic lst, input logic [ADDR_BITS-1:0] adr);
    req_t r;
    cmd_t c0;
    cmd_t c1;
    int   n;
    logic miss;
    r.wr  = wr;
    r.lst = lst;
    r.tid = next_tid;
    r.adr = adr;
    next_tid = next_tid + 1'b1;
    n = expected_cmds(r, m_open, m_row, m_bank, c0, c1);
    miss = (c0.cmd == CMD_PREC);
    r.ack = !miss;
    exp_q.push_back(c0);
    if (n == 2) begin
      exp_q.push_back(c1);
    end
    if (miss) begin
      m_open = 1'b0;
    end else begin
      if (!m_open) begin
        m_row  = adr[ADDR_BITS-1 -: ROW_BITS];
        m_bank = adr[COL_BITS +: BANK_BITS];
      end
      m_open = !lst;
    end
    if (wr) begin
      wr_list.push_back(r);
    end else begin
      rd_list.push_back(r);
    end
  endtask

  task automatic set_port(input logic wr, input logic req, input logic lst,
                          input logic [TID_BITS-1:0] tid, input logic [ADDR_BITS-1:0] adr);
    if (wr) begin
      mem_wrreq_i = req;
      mem_wrlst_i = lst;
      mem_wrtid_i = tid;
      mem_wradr_i = adr;
    end else begin
      mem_rdreq_i = req;
      mem_rdlst_i = lst;
      mem_rdtid_i = tid;
      mem_rdadr_i = adr;
    end
  endtask

  // requester for one port that holds each request until ack or err
  task automatic drive_port(input logic wr);
    req_t  r;
    logic  ack;
    logic  err;
    int    n;
    string ack_name;
    string err_name;
    ack_name = wr ? "mem_wrack_o" : "mem_rdack_o";
    err_name = wr ? "mem_wrerr_o" : "mem_rderr_o";
    n = wr ? wr_list.size() : rd_list.size();
    for (int i = 0; i < n; i++) begin
      r = wr ? wr_list.pop_front() : rd_list.pop_front();
      set_port(wr, 1'b1, r.lst, r.tid, r.adr);
      @(negedge clock_i);
      ack = wr ? mem_wrack_o : mem_rdack_o;
      err = wr ? mem_wrerr_o : mem_rderr_o;
      // no strobe can answer this soon
      check_value(ack_name, ack, 0);
      check_value(err_name, err, 0);
      while (!ack && !err) begin
        @(negedge clock_i);
        ack = wr ? mem_wrack_o : mem_rdack_o;
        err = wr ? mem_wrerr_o : mem_rderr_o;
      end
      check_value(ack_name, ack, r.ack);
      check_value(err_name, err, !r.ack);
    end
    if (n > 0) begin
      set_port(wr, 1'b0, 1'b0, '0, '0);
      @(negedge clock_i);
      check_value(ack_name, wr ? mem_wrack_o : mem_rdack_o, 0);
      check_value(err_name, wr ? mem_wrerr_o : mem_rderr_o, 0);
    end
  endtask

  task automatic run_ports();
    fork
      drive_port(1'b0);
      drive_port(1'b1);
    join
  endtask

  // data layer model drives random ready and occasional refresh and records accepted commands
  // acceptance is known here since ready for the next edge is chosen here
  always @(negedge clock_i) begin : data_layer
    cmd_t cur;
    logic rdy_new;
    logic ref_done;
    check_value("cfg_rdy_o", cfg_rdy_o, ddl_rdy_i);
    cur = '{cmd: ddl_cmd_o, tid: ddl_tid_o, ba: ddl_ba_o, adr: ddl_adr_o};
    if (held) begin
      check_value("ddl_req_o", ddl_req_o, 1);
      check_value("ddl_cmd_o", cur.cmd, held_cmd.cmd);
      check_value("ddl_tid_o", cur.tid, held_cmd.tid);
      check_value("ddl_ba_o", cur.ba, held_cmd.ba);
      check_value("ddl_adr_o", cur.adr, held_cmd.adr);
    end
    if (stall_cnt >= MAX_STALL) begin
      rdy_new = 1'b1;
    end else begin
      rdy_new = rand_bits() & 1;
    end
    stall_cnt = rdy_new ? 0 : stall_cnt + 1;
    ref_done = 1'b0;
    if (!reset_i && ddl_req_o && rdy_new) begin
      acc_q.push_back(cur);
      if (cur.cmd == CMD_REFR) begin
        if (!ref_pending) begin
          stop_on_error("REFRESH issued without a refresh request");
        end
        ref_pending = 1'b0;
        ddl_ref_i = 1'b0;
        ref_done = 1'b1;
        refresh_count = refresh_count + 1;
      end
      if (cur.cmd == CMD_ACTV && ref_when_loaded) begin
        stop_on_error("ACTIVATE chosen while a refresh was requested");
      end
    end
    held = !reset_i && ddl_req_o && !rdy_new;
    held_cmd = cur;
    // ref stays low at the edge that retires the refresh state
    if (!reset_i && !ref_pending && !ref_done && ($unsigned(rand_bits()) % 24 == 0)) begin
      ref_pending = 1'b1;
      ddl_ref_i = 1'b1;
    end
    // refresh level seen by the fsm at the edge that loads the next command
    if (rdy_new) begin
      ref_when_loaded = ddl_ref_i;
    end
    ddl_rdy_i = rdy_new;
  end

  // compare accepted commands with the reference stream
  always @(posedge clock_i) begin : compare
    cmd_t got;
    cmd_t e;
    while (acc_q.size() > 0) begin
      got = acc_q.pop_front();
      if (got.cmd == CMD_REFR) begin
        // refresh only between bursts so the next expected command is an activate
        if (exp_q.size() > 0 && exp_q[0].cmd != CMD_ACTV) begin
          stop_on_error("REFRESH issued inside an open burst");
        end
      end else if (exp_q.size() == 0) begin
        stop_on_error("data layer accepted a command that no request asked for");
      end else begin
        e = exp_q.pop_front();
        check_value("ddl_cmd_o", got.cmd, e.cmd);
        check_value("ddl_ba_o", got.ba, e.ba);
        check_value("ddl_tid_o", got.tid, e.tid);
        if (e.cmd == CMD_PREC) begin
          check_value("ddl_adr_o[10]", got.adr[A10_BIT], e.adr[A10_BIT]);
        end else begin
          check_value("ddl_adr_o", got.adr, e.adr);
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    stop_on_error("timeout, the scheduler stopped making progress");
  end

  initial begin : main
    logic                 p_req;
    ddr3_cmd_e            p_cmd;
    logic [BANK_BITS-1:0] p_ba;
    logic [ROW_BITS-1:0]  p_adr;
    logic [ROW_BITS-1:0]  row;
    logic [BANK_BITS-1:0] bank;
    logic                 wr;
    int                   len;
    clock_i = 1'b0;
    reset_i = 1'b1;
    set_port(1'b0, 1'b0, 1'b0, '0, '0);
    set_port(1'b1, 1'b0, 1'b0, '0, '0);
    cfg_req_i = 1'b0;
    cfg_cmd_i = CMD_NOOP;
    cfg_ba_i = '0;
    cfg_adr_i = '0;
    ddl_rdy_i = 1'b0;
    ddl_ref_i = 1'b0;
    m_open = 1'b0;
    m_row = '0;
    m_bank = '0;
    next_tid = '0;
    stall_cnt = 0;
    held = 1'b0;
    held_cmd = '0;
    ref_pending = 1'b0;
    ref_when_loaded = 1'b0;
    refresh_count = 0;
    p_req = 1'b0;
    p_cmd = CMD_NOOP;
    p_ba = '0;
    p_adr = '0;

    // configuration passes through one cycle late while reset is high
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clock_i);
      if (i > 0) begin
        check_value("ddl_req_o", ddl_req_o, p_req);
        check_value("ddl_cmd_o", ddl_cmd_o, p_cmd);
        check_value("ddl_ba_o", ddl_ba_o, p_ba);
        check_value("ddl_adr_o", ddl_adr_o, p_adr);
      end
      if (i < RESET_CYCLES - 2) begin
        cfg_req_i = rand_bits() & 1;
        cfg_cmd_i = ddr3_cmd_e'(rand_bits() & 7);
        cfg_ba_i = rand_bits();
        cfg_adr_i = rand_bits();
      end else begin
        cfg_req_i = 1'b0;
        cfg_cmd_i = CMD_NOOP;
        cfg_ba_i = '0;
        cfg_adr_i = '0;
      end
      p_req = cfg_req_i;
      p_cmd = cfg_cmd_i;
      p_ba = cfg_ba_i;
      p_adr = cfg_adr_i;
    end
    reset_i = 1'b0;
    check_value("mem_rdack_o", mem_rdack_o, 0);
    check_value("mem_wrack_o", mem_wrack_o, 0);
    check_value("mem_rderr_o", mem_rderr_o, 0);
    check_value("mem_wrerr_o", mem_wrerr_o, 0);

    // single last read, then single last write
    plan_request(1'b0, 1'b1, rand_bits());
    run_ports();
    plan_request(1'b1, 1'b1, rand_bits());
    run_ports();

    // bursts in one row with one activate each
    row = rand_bits();
    bank = rand_bits();
    for (int i = 0; i < 4; i++) begin
      plan_request(1'b1, i == 3, make_addr(row, bank, 7'(i * 5)));
    end
    run_ports();
    for (int i = 0; i < 3; i++) begin
      plan_request(1'b0, i == 2, make_addr(row + 1'b1, bank, rand_bits()));
    end
    run_ports();

    // read and write together where the read burst goes first
    row = rand_bits();
    plan_request(1'b0, 1'b0, make_addr(row, 3'd2, 7'd1));
    plan_request(1'b0, 1'b1, make_addr(row, 3'd2, 7'd2));
    plan_request(1'b1, 1'b1, rand_bits());
    run_ports();

    // follow-on misses to another row and then another bank
    row = rand_bits();
    plan_request(1'b1, 1'b0, make_addr(row, 3'd5, 7'd9));
    plan_request(1'b1, 1'b0, make_addr(row + 1'b1, 3'd5, 7'd9));
    run_ports();
    plan_request(1'b0, 1'b0, make_addr(row, 3'd1, 7'd3));
    plan_request(1'b0, 1'b1, make_addr(row, 3'd6, 7'd3));
    run_ports();

    // random bursts where some end in a miss
    for (int b = 0; b < 6; b++) begin
      wr = rand_bits() & 1;
      len = 1 + $unsigned(rand_bits()) % 3;
      row = rand_bits();
      bank = rand_bits();
      for (int k = 0; k < len; k++) begin
        if (k > 0 && ($unsigned(rand_bits()) % 4 == 0)) begin
          plan_request(wr, 1'b0, make_addr(row + 1'b1, bank, rand_bits()));
          break;
        end
        plan_request(wr, k == len - 1, make_addr(row, bank, rand_bits()));
      end
      run_ports();
    end

    // let an outstanding refresh finish
    while (exp_q.size() > 0 || acc_q.size() > 0 || ref_pending) begin
      @(negedge clock_i);
    end
    if (refresh_count == 0) begin
      stop_on_error("no REFRESH was issued during the run");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- ddr3_sched_top.f
design/ddr3_sched_pkg.sv
design/ddr3_req_decode.sv
design/ddr3_cmd_fsm.sv
design/ddr3_resp_gen.sv
design/ddr3_sched_top.sv
tests/ddr3_sched_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := ddr3_sched_tb
FILELIST  := ddr3_sched_top.f
OBJDIR    := obj_dir
VFLAGS    := --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJDIR)
